//--- Bender.yml
package:
  name: lq

sources:
  - lq_pkg.sv
  - lq_ptr_ctrl.sv
  - lq_entry_array.sv
  - lq_uncache_fsm.sv
  - lq_wb_select.sv
  - lq_top.sv
  - target: simulation
    files:
      - lq_sva.sv
      - tb_lq_top.sv

//--- filelist.f
lq_pkg.sv
lq_ptr_ctrl.sv
lq_entry_array.sv
lq_uncache_fsm.sv
lq_wb_select.sv
lq_top.sv
lq_sva.sv
tb_lq_top.sv

//--- lq_entry_array.sv
`default_nettype none
`timescale 1ns/1ps

module lq_entry_array
    import lq_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                dis_en_i,
    input  wire logic [LQ_IDX_W-1:0] tail_idx_i,
    input  wire logic [LQ_IDX_W-1:0] head_idx_i,
    input  wire logic                commit_en_i,
    input  wire logic                iss_en_i,
    input  wire logic [LQ_IDX_W-1:0] iss_idx_i,
    input  wire logic [ADDR_W-1:0]   iss_addr_i,
    input  wire logic [SIZE_W-1:0]   iss_size_i,
    input  wire logic                iss_uext_i,
    input  wire logic [RD_W-1:0]     iss_rd_i,
    input  wire logic                iss_miss_i,
    input  wire logic                iss_uncache_i,
    input  wire logic [XLEN-1:0]     iss_data_i,
    input  wire logic                refill_en_i,
    input  wire logic [LQ_IDX_W-1:0] refill_idx_i,
    input  wire logic [XLEN-1:0]     refill_data_i,
    input  wire logic                wb_fire_i,
    input  wire logic [LQ_IDX_W-1:0] wb_idx_i,
    output logic                     head_unc_ready_o,
    output logic [ADDR_W-1:0]        head_addr_o,
    output logic [SIZE_W-1:0]        head_size_o,
    output logic                     head_uext_o,
    output logic [RD_W-1:0]          head_rd_o,
    output logic                     cand_valid_o,
    output logic [LQ_IDX_W-1:0]      cand_idx_o,
    output logic [XLEN-1:0]          cand_raw_o,
    output logic [OFS_W-1:0]         cand_ofs_o,
    output logic [SIZE_W-1:0]        cand_size_o,
    output logic                     cand_uext_o,
    output logic [RD_W-1:0]          cand_rd_o
);

    logic [LQ_DEPTH-1:0] valid, issued, miss, uncache, data_ok, wb_done;
    logic [LQ_DEPTH-1:0] waiting;
    logic                alloc;

    logic [XLEN-1:0]     raw_q  [LQ_DEPTH];
    logic [ADDR_W-1:0]   addr_q [LQ_DEPTH];
    logic [SIZE_W-1:0]   size_q [LQ_DEPTH];
    logic                uext_q [LQ_DEPTH];
    logic [RD_W-1:0]     rd_q   [LQ_DEPTH];

    // tail slot still occupied means the queue is full
    assign alloc = dis_en_i && !valid[tail_idx_i];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid   <= '0;
            issued  <= '0;
            miss    <= '0;
            uncache <= '0;
            data_ok <= '0;
            wb_done <= '0;
        end else begin
            if (alloc) begin
                valid[tail_idx_i]   <= 1'b1;
                issued[tail_idx_i]  <= 1'b0;
                miss[tail_idx_i]    <= 1'b0;
                uncache[tail_idx_i] <= 1'b0;
                data_ok[tail_idx_i] <= 1'b0;
                wb_done[tail_idx_i] <= 1'b0;
            end
            if (iss_en_i) begin
                issued[iss_idx_i]  <= 1'b1;
                miss[iss_idx_i]    <= iss_miss_i;
                uncache[iss_idx_i] <= iss_uncache_i;
                data_ok[iss_idx_i] <= !iss_miss_i && !iss_uncache_i;
            end
            if (refill_en_i && miss[refill_idx_i]) begin
                data_ok[refill_idx_i] <= 1'b1;
            end
            if (wb_fire_i) begin
                wb_done[wb_idx_i] <= 1'b1;
            end
            if (commit_en_i) begin
                valid[head_idx_i] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (iss_en_i) begin
            raw_q[iss_idx_i]  <= iss_data_i;
            addr_q[iss_idx_i] <= iss_addr_i;
            size_q[iss_idx_i] <= iss_size_i;
            uext_q[iss_idx_i] <= iss_uext_i;
            rd_q[iss_idx_i]   <= iss_rd_i;
        end
        if (refill_en_i) begin
            raw_q[refill_idx_i] <= refill_data_i;
        end
    end

    assign head_unc_ready_o = valid[head_idx_i] && issued[head_idx_i] &&
                              uncache[head_idx_i] && !wb_done[head_idx_i];
    assign head_addr_o = addr_q[head_idx_i];
    assign head_size_o = size_q[head_idx_i];
    assign head_uext_o = uext_q[head_idx_i];
    assign head_rd_o   = rd_q[head_idx_i];

    assign waiting = valid & issued & data_ok & ~wb_done;

    // lowest index wins
    always_comb begin
        cand_valid_o = 1'b0;
        cand_idx_o   = '0;
        for (int i = LQ_DEPTH - 1; i >= 0; i--) begin
            if (waiting[i]) begin
                cand_valid_o = 1'b1;
                cand_idx_o   = LQ_IDX_W'(i);
            end
        end
    end

    assign cand_raw_o  = raw_q[cand_idx_o];
    assign cand_ofs_o  = addr_q[cand_idx_o][OFS_W-1:0];
    assign cand_size_o = size_q[cand_idx_o];
    assign cand_uext_o = uext_q[cand_idx_o];
    assign cand_rd_o   = rd_q[cand_idx_o];

endmodule

`default_nettype wire

//--- lq_pkg.sv
`default_nettype none

package lq_pkg;

    // queue geometry
    localparam int LQ_DEPTH = 8;
    localparam int LQ_IDX_W = 3;

    localparam int XLEN   = 32;
    localparam int ADDR_W = 32;
    localparam int RD_W   = 5;

    // byte offset within a word
    localparam int OFS_W  = 2;

    // access size codes
    localparam int SIZE_W = 2;
    localparam logic [SIZE_W-1:0] SIZE_B   = 2'b00;
    localparam logic [SIZE_W-1:0] SIZE_H   = 2'b01;
    localparam logic [SIZE_W-1:0] SIZE_W32 = 2'b10;

    // uncached read sequencer states
    localparam int UNC_ST_W = 2;
    localparam logic [UNC_ST_W-1:0] UNC_IDLE = 2'd0;
    localparam logic [UNC_ST_W-1:0] UNC_REQ  = 2'd1;
    localparam logic [UNC_ST_W-1:0] UNC_WAIT = 2'd2;
    localparam logic [UNC_ST_W-1:0] UNC_WB   = 2'd3;

endpackage

`default_nettype wire

//--- lq_ptr_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

module lq_ptr_ctrl
    import lq_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                dis_en_i,
    input  wire logic                commit_en_i,
    output logic [LQ_IDX_W-1:0]      head_idx_o,
    output logic [LQ_IDX_W-1:0]      tail_idx_o,
    output logic                     full_o
);

    // msb is the wrap bit
    logic [LQ_IDX_W:0] head_ptr;
    logic [LQ_IDX_W:0] tail_ptr;

    assign head_idx_o = head_ptr[LQ_IDX_W-1:0];
    assign tail_idx_o = tail_ptr[LQ_IDX_W-1:0];

    // same slot, different lap
    assign full_o = (head_ptr[LQ_IDX_W-1:0] == tail_ptr[LQ_IDX_W-1:0]) &&
                    (head_ptr[LQ_IDX_W] != tail_ptr[LQ_IDX_W]);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head_ptr <= '0;
            tail_ptr <= '0;
        end else begin
            if (dis_en_i && !full_o) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            if (commit_en_i) begin
                head_ptr <= head_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- lq_sva.sv
`default_nettype none
`timescale 1ns/1ps

module lq_sva
    import lq_pkg::*;
(
    input wire logic                clk,
    input wire logic                rst,
    input wire logic                ar_valid_o,
    input wire logic                ar_ready_i,
    input wire logic [ADDR_W-1:0]   ar_addr_o,
    input wire logic                wb_valid_o,
    input wire logic                full_o,
    input wire logic [LQ_IDX_W-1:0] lq_idx_o
);

    // failed assertion count
    int fail_count;

    initial fail_count = 0;

    // request held until accepted
    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        (ar_valid_o && !ar_ready_i) |=> (ar_valid_o && $stable(ar_addr_o)))
        else begin
            fail_count++;
            $error("ar_addr_o or ar_valid_o changed before ar_ready_i");
        end

    a_wb_idle_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !wb_valid_o)
        else begin
            fail_count++;
            $error("wb_valid_o high in the first cycle after reset");
        end

    a_tail_hold_full: assert property (@(posedge clk) disable iff (rst)
        full_o |=> $stable(lq_idx_o))
        else begin
            fail_count++;
            $error("lq_idx_o moved while the queue was full");
        end

endmodule

`default_nettype wire

//--- lq_top.sv
`default_nettype none
`timescale 1ns/1ps

module lq_top
    import lq_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                dis_en_i,
    output logic [LQ_IDX_W-1:0]      lq_idx_o,
    output logic                     full_o,
    input  wire logic                iss_en_i,
    input  wire logic [LQ_IDX_W-1:0] iss_idx_i,
    input  wire logic [ADDR_W-1:0]   iss_addr_i,
    input  wire logic [SIZE_W-1:0]   iss_size_i,
    input  wire logic                iss_uext_i,
    input  wire logic [RD_W-1:0]     iss_rd_i,
    input  wire logic                iss_miss_i,
    input  wire logic                iss_uncache_i,
    input  wire logic [XLEN-1:0]     iss_data_i,
    input  wire logic                refill_en_i,
    input  wire logic [LQ_IDX_W-1:0] refill_idx_i,
    input  wire logic [XLEN-1:0]     refill_data_i,
    input  wire logic                commit_en_i,
    output logic                     wb_valid_o,
    output logic [LQ_IDX_W-1:0]      wb_idx_o,
    output logic [RD_W-1:0]          wb_rd_o,
    output logic [XLEN-1:0]          wb_data_o,
    input  wire logic                wb_ready_i,
    output logic                     ar_valid_o,
    output logic [ADDR_W-1:0]        ar_addr_o,
    input  wire logic                ar_ready_i,
    input  wire logic                r_valid_i,
    input  wire logic [XLEN-1:0]     r_data_i
);

    logic [LQ_IDX_W-1:0] head_idx;
    logic                head_unc_ready;
    logic [ADDR_W-1:0]   head_addr;
    logic [SIZE_W-1:0]   head_size;
    logic                head_uext;
    logic [RD_W-1:0]     head_rd;
    logic                cand_valid;
    logic [LQ_IDX_W-1:0] cand_idx;
    logic [XLEN-1:0]     cand_raw;
    logic [OFS_W-1:0]    cand_ofs;
    logic [SIZE_W-1:0]   cand_size;
    logic                cand_uext;
    logic [RD_W-1:0]     cand_rd;
    logic                unc_wb_valid;
    logic [XLEN-1:0]     unc_raw;
    logic                wb_fire;

    lq_ptr_ctrl u_ptr_ctrl (
        .clk         (clk),
        .rst         (rst),
        .dis_en_i    (dis_en_i),
        .commit_en_i (commit_en_i),
        .head_idx_o  (head_idx),
        .tail_idx_o  (lq_idx_o),
        .full_o      (full_o)
    );

    lq_entry_array u_entry_array (
        .clk              (clk),
        .rst              (rst),
        .dis_en_i         (dis_en_i),
        .tail_idx_i       (lq_idx_o),
        .head_idx_i       (head_idx),
        .commit_en_i      (commit_en_i),
        .iss_en_i         (iss_en_i),
        .iss_idx_i        (iss_idx_i),
        .iss_addr_i       (iss_addr_i),
        .iss_size_i       (iss_size_i),
        .iss_uext_i       (iss_uext_i),
        .iss_rd_i         (iss_rd_i),
        .iss_miss_i       (iss_miss_i),
        .iss_uncache_i    (iss_uncache_i),
        .iss_data_i       (iss_data_i),
        .refill_en_i      (refill_en_i),
        .refill_idx_i     (refill_idx_i),
        .refill_data_i    (refill_data_i),
        .wb_fire_i        (wb_fire),
        .wb_idx_i         (wb_idx_o),
        .head_unc_ready_o (head_unc_ready),
        .head_addr_o      (head_addr),
        .head_size_o      (head_size),
        .head_uext_o      (head_uext),
        .head_rd_o        (head_rd),
        .cand_valid_o     (cand_valid),
        .cand_idx_o       (cand_idx),
        .cand_raw_o       (cand_raw),
        .cand_ofs_o       (cand_ofs),
        .cand_size_o      (cand_size),
        .cand_uext_o      (cand_uext),
        .cand_rd_o        (cand_rd)
    );

    lq_uncache_fsm u_uncache_fsm (
        .clk              (clk),
        .rst              (rst),
        .head_unc_ready_i (head_unc_ready),
        .head_addr_i      (head_addr),
        .ar_ready_i       (ar_ready_i),
        .r_valid_i        (r_valid_i),
        .r_data_i         (r_data_i),
        .wb_fire_i        (wb_fire),
        .ar_valid_o       (ar_valid_o),
        .ar_addr_o        (ar_addr_o),
        .unc_wb_valid_o   (unc_wb_valid),
        .unc_raw_o        (unc_raw)
    );

    lq_wb_select u_wb_select (
        .unc_wb_valid_i (unc_wb_valid),
        .unc_raw_i      (unc_raw),
        .head_idx_i     (head_idx),
        .head_addr_i    (head_addr),
        .head_size_i    (head_size),
        .head_uext_i    (head_uext),
        .head_rd_i      (head_rd),
        .cand_valid_i   (cand_valid),
        .cand_idx_i     (cand_idx),
        .cand_raw_i     (cand_raw),
        .cand_ofs_i     (cand_ofs),
        .cand_size_i    (cand_size),
        .cand_uext_i    (cand_uext),
        .cand_rd_i      (cand_rd),
        .wb_ready_i     (wb_ready_i),
        .wb_valid_o     (wb_valid_o),
        .wb_idx_o       (wb_idx_o),
        .wb_rd_o        (wb_rd_o),
        .wb_data_o      (wb_data_o),
        .wb_fire_o      (wb_fire)
    );

endmodule

`default_nettype wire

//--- lq_uncache_fsm.sv
`default_nettype none
`timescale 1ns/1ps

module lq_uncache_fsm
    import lq_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              head_unc_ready_i,
    input  wire logic [ADDR_W-1:0] head_addr_i,
    input  wire logic              ar_ready_i,
    input  wire logic              r_valid_i,
    input  wire logic [XLEN-1:0]   r_data_i,
    input  wire logic              wb_fire_i,
    output logic                   ar_valid_o,
    output logic [ADDR_W-1:0]      ar_addr_o,
    output logic                   unc_wb_valid_o,
    output logic [XLEN-1:0]        unc_raw_o
);

    logic [UNC_ST_W-1:0] state;
    logic [ADDR_W-1:0]   addr_q;
    logic [XLEN-1:0]     raw_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= UNC_IDLE;
        end else begin
            case (state)
                UNC_IDLE: begin
                    if (head_unc_ready_i) begin
                        state <= UNC_REQ;
                    end
                end
                UNC_REQ: begin
                    if (ar_ready_i) begin
                        state <= UNC_WAIT;
                    end
                end
                UNC_WAIT: begin
                    if (r_valid_i) begin
                        state <= UNC_WB;
                    end
                end
                default: begin
                    // hold the result until the writeback is taken
                    if (wb_fire_i) begin
                        state <= UNC_IDLE;
                    end
                end
            endcase
        end
    end

    // word address, stable for the whole request
    always_ff @(posedge clk) begin
        if (state == UNC_IDLE && head_unc_ready_i) begin
            addr_q <= {head_addr_i[ADDR_W-1:OFS_W], {OFS_W{1'b0}}};
        end
        if (state == UNC_WAIT && r_valid_i) begin
            raw_q <= r_data_i;
        end
    end

    assign ar_valid_o     = (state == UNC_REQ);
    assign ar_addr_o      = addr_q;
    assign unc_wb_valid_o = (state == UNC_WB);
    assign unc_raw_o      = raw_q;

endmodule

`default_nettype wire

//--- lq_wb_select.sv
`default_nettype none
`timescale 1ns/1ps

module lq_wb_select
    import lq_pkg::*;
(
    input  wire logic                unc_wb_valid_i,
    input  wire logic [XLEN-1:0]     unc_raw_i,
    input  wire logic [LQ_IDX_W-1:0] head_idx_i,
    input  wire logic [ADDR_W-1:0]   head_addr_i,
    input  wire logic [SIZE_W-1:0]   head_size_i,
    input  wire logic                head_uext_i,
    input  wire logic [RD_W-1:0]     head_rd_i,
    input  wire logic                cand_valid_i,
    input  wire logic [LQ_IDX_W-1:0] cand_idx_i,
    input  wire logic [XLEN-1:0]     cand_raw_i,
    input  wire logic [OFS_W-1:0]    cand_ofs_i,
    input  wire logic [SIZE_W-1:0]   cand_size_i,
    input  wire logic                cand_uext_i,
    input  wire logic [RD_W-1:0]     cand_rd_i,
    input  wire logic                wb_ready_i,
    output logic                     wb_valid_o,
    output logic [LQ_IDX_W-1:0]      wb_idx_o,
    output logic [RD_W-1:0]          wb_rd_o,
    output logic [XLEN-1:0]          wb_data_o,
    output logic                     wb_fire_o
);

    logic [XLEN-1:0]   sel_raw;
    logic [OFS_W-1:0]  sel_ofs;
    logic [SIZE_W-1:0] sel_size;
    logic              sel_uext;
    logic [XLEN-1:0]   shifted;
    logic              sign_b;
    logic              sign_h;

    // uncached result is at the head, so it goes first
    assign wb_valid_o = unc_wb_valid_i || cand_valid_i;
    assign wb_idx_o   = unc_wb_valid_i ? head_idx_i : cand_idx_i;
    assign wb_rd_o    = unc_wb_valid_i ? head_rd_i : cand_rd_i;
    assign sel_raw    = unc_wb_valid_i ? unc_raw_i : cand_raw_i;
    assign sel_ofs    = unc_wb_valid_i ? head_addr_i[OFS_W-1:0] : cand_ofs_i;
    assign sel_size   = unc_wb_valid_i ? head_size_i : cand_size_i;
    assign sel_uext   = unc_wb_valid_i ? head_uext_i : cand_uext_i;

    assign wb_fire_o = wb_valid_o && wb_ready_i;

    // bring the addressed byte down to bit 0
    assign shifted = sel_raw >> {sel_ofs, 3'b000};

    assign sign_b = !sel_uext && shifted[7];
    assign sign_h = !sel_uext && shifted[15];

    always_comb begin
        case (sel_size)
            SIZE_B: begin
                wb_data_o = {{(XLEN-8){sign_b}}, shifted[7:0]};
            end
            SIZE_H: begin
                wb_data_o = {{(XLEN-16){sign_h}}, shifted[15:0]};
            end
            SIZE_W32: begin
                wb_data_o = shifted;
            end
            default: begin
                wb_data_o = shifted;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- tb_lq_top.sv
`default_nettype none
`timescale 1ns/1ps

module tb_lq_top
    import lq_pkg::*;
();

    localparam int MAX_CYCLES = 4000;

    logic                clk, rst;
    logic                dis_en_i, iss_en_i, iss_uext_i, iss_miss_i, iss_uncache_i;
    logic [LQ_IDX_W-1:0] iss_idx_i, refill_idx_i, lq_idx_o, wb_idx_o;
    logic [ADDR_W-1:0]   iss_addr_i, ar_addr_o;
    logic [SIZE_W-1:0]   iss_size_i;
    logic [RD_W-1:0]     iss_rd_i, wb_rd_o;
    logic [XLEN-1:0]     iss_data_i, refill_data_i, wb_data_o, r_data_i;
    logic                refill_en_i, commit_en_i, wb_ready_i, ar_ready_i, r_valid_i;
    logic                full_o, wb_valid_o, ar_valid_o;

    integer seed;
    int     err_count, tests_ok, tests_bad, loads, cycles;
    int     tb_head, tb_tail, dis_count, com_count;
    bit     bp_mode, rd_pending;
    int     rd_delay;
    logic [ADDR_W-1:0] rd_addr;

    // expected state per queue slot
    logic [XLEN-1:0]   exp_val   [LQ_DEPTH];
    logic [RD_W-1:0]   exp_rd    [LQ_DEPTH];
    logic [ADDR_W-1:0] exp_addr  [LQ_DEPTH];
    logic [XLEN-1:0]   miss_word [LQ_DEPTH];
    bit                pending   [LQ_DEPTH];
    bit                done      [LQ_DEPTH];
    bit                unc       [LQ_DEPTH];
    int                miss_q    [$];

    lq_top u_lq_top (.*);

    bind lq_top lq_sva u_lq_sva (
        .clk        (clk),
        .rst        (rst),
        .ar_valid_o (ar_valid_o),
        .ar_ready_i (ar_ready_i),
        .ar_addr_o  (ar_addr_o),
        .wb_valid_o (wb_valid_o),
        .full_o     (full_o),
        .lq_idx_o   (lq_idx_o)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic int rand_below(input int n);
        rand_below = $unsigned($random(seed)) % n;
    endfunction

    // word the uncached memory returns for an aligned address
    function automatic logic [XLEN-1:0] mem_word(input logic [ADDR_W-1:0] addr);
        mem_word = (addr * 32'h9E37_79B1) ^ {addr[15:0], addr[31:16]};
    endfunction

    function automatic logic [XLEN-1:0] ref_result(input logic [XLEN-1:0] raw,
            input logic [OFS_W-1:0] ofs, input logic [SIZE_W-1:0] size, input logic uext);
        logic [7:0]  b;
        logic [15:0] h;
        b = raw[ofs*8 +: 8];
        h = ofs[1] ? raw[31:16] : raw[15:0];
        case (size)
            SIZE_B:  ref_result = uext ? {24'h0, b} : {{24{b[7]}}, b};
            SIZE_H:  ref_result = uext ? {16'h0, h} : {{16{h[15]}}, h};
            default: ref_result = raw;
        endcase
    endfunction

    task automatic dispatch_one(output int idx);
        while (full_o) begin
            @(posedge clk);
            #2;
        end
        if (lq_idx_o !== LQ_IDX_W'(tb_tail)) begin
            $display("ERR lq_idx_o exp %h act %h", LQ_IDX_W'(tb_tail), lq_idx_o);
            err_count++;
        end
        idx = tb_tail;
        done[idx] = 1'b0;
        dis_en_i = 1'b1;
        @(posedge clk);
        #2;
        dis_en_i = 1'b0;
        tb_tail = (tb_tail + 1) % LQ_DEPTH;
        dis_count++;
    endtask

    // kind 0 hit, 1 miss, 2 uncached
    task automatic issue_load(input int idx, input int kind);
        logic [ADDR_W-1:0] addr;
        logic [XLEN-1:0]   raw;
        logic [SIZE_W-1:0] size;
        logic              uext;
        logic [RD_W-1:0]   rd;
        size = SIZE_W'(rand_below(3));
        addr = $random(seed);
        if (size == SIZE_H) addr[0] = 1'b0;
        if (size == SIZE_W32) addr[1:0] = 2'b00;
        uext = rand_below(2);
        rd   = RD_W'(rand_below(32));
        raw  = $random(seed);
        if (kind == 2) raw = mem_word({addr[ADDR_W-1:2], 2'b00});
        exp_val[idx]  = ref_result(raw, addr[1:0], size, uext);
        exp_rd[idx]   = rd;
        exp_addr[idx] = addr;
        unc[idx]      = (kind == 2);
        pending[idx]  = 1'b1;
        if (kind == 1) begin
            miss_word[idx] = raw;
            miss_q.push_back(idx);
        end
        iss_en_i      = 1'b1;
        iss_idx_i     = LQ_IDX_W'(idx);
        iss_addr_i    = addr;
        iss_size_i    = size;
        iss_uext_i    = uext;
        iss_rd_i      = rd;
        iss_miss_i    = (kind == 1);
        iss_uncache_i = (kind == 2);
        iss_data_i    = (kind == 0) ? raw : ~raw;
        loads++;
        @(posedge clk);
        #2;
        iss_en_i = 1'b0;
    endtask

    // refills come back in random order
    task automatic refill_all();
        int k;
        while (miss_q.size() > 0) begin
            k = rand_below(miss_q.size());
            refill_en_i   = 1'b1;
            refill_idx_i  = LQ_IDX_W'(miss_q[k]);
            refill_data_i = miss_word[miss_q[k]];
            miss_q.delete(k);
            @(posedge clk);
            #2;
            refill_en_i = 1'b0;
        end
    endtask

    task automatic drain_queue();
        while (dis_count != com_count) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic run_group(input int n, input int mode);
        int idx;
        for (int i = 0; i < n; i++) begin
            dispatch_one(idx);
            issue_load(idx, (mode < 2) ? mode : rand_below(mode));
        end
        refill_all();
        drain_queue();
    endtask

    task automatic report_test(input string name, input int start_err);
        int n_err;
        n_err = err_count - start_err;
        if (n_err == 0) tests_ok++;
        else tests_bad++;
        $display("test %-12s %0d loads, %0d errors", name, loads, n_err);
    endtask

    task automatic run_test(input string name, input int groups, input int mode, input bit bp);
        int start_err;
        start_err = err_count;
        loads = 0;
        bp_mode = bp;
        repeat (groups) run_group(1 + rand_below(LQ_DEPTH), mode);
        bp_mode = 1'b0;
        report_test(name, start_err);
    endtask

    task automatic full_wrap_test();
        int idx_list[$];
        int idx;
        int start_err;
        logic [LQ_IDX_W-1:0] held;
        start_err = err_count;
        loads = 0;
        repeat (LQ_DEPTH) begin
            dispatch_one(idx);
            idx_list.push_back(idx);
        end
        if (full_o !== 1'b1) begin
            $display("ERR full_o exp %h act %h", 1'b1, full_o);
            err_count++;
        end
        held = lq_idx_o;
        repeat (2) begin
            dis_en_i = 1'b1;
            @(posedge clk);
            #2;
            dis_en_i = 1'b0;
        end
        if (lq_idx_o !== held) begin
            $display("ERR lq_idx_o exp %h act %h", held, lq_idx_o);
            err_count++;
        end
        foreach (idx_list[i]) issue_load(idx_list[i], 0);
        drain_queue();
        run_group(LQ_DEPTH, 0);
        report_test("full_wrap", start_err);
    endtask

    // sampled mid-cycle ahead of the transfer edge
    always @(negedge clk) begin
        if (!rst && wb_valid_o && wb_ready_i) begin
            if (!pending[wb_idx_o]) begin
                $display("writeback from entry %0d which has no load waiting", wb_idx_o);
                err_count++;
            end else begin
                if (wb_rd_o !== exp_rd[wb_idx_o]) begin
                    $display("ERR wb_rd_o exp %h act %h", exp_rd[wb_idx_o], wb_rd_o);
                    err_count++;
                end
                if (wb_data_o !== exp_val[wb_idx_o]) begin
                    $display("ERR wb_data_o exp %h act %h", exp_val[wb_idx_o], wb_data_o);
                    err_count++;
                end
            end
            pending[wb_idx_o] = 1'b0;
            done[wb_idx_o]    = 1'b1;
        end
        if (!rst && ar_valid_o && !(unc[tb_head] && pending[tb_head])) begin
            $display("uncached read requested while older loads are still in the queue");
            err_count++;
        end else if (!rst && ar_valid_o && ar_ready_i) begin
            if (ar_addr_o !== {exp_addr[tb_head][ADDR_W-1:2], 2'b00}) begin
                $display("ERR ar_addr_o exp %h act %h",
                         {exp_addr[tb_head][ADDR_W-1:2], 2'b00}, ar_addr_o);
                err_count++;
            end
            rd_pending = 1'b1;
            rd_addr    = ar_addr_o;
            rd_delay   = rand_below(4);
        end
    end

    // memory model for uncached reads
    initial begin
        forever begin
            @(posedge clk);
            #2;
            r_valid_i = 1'b0;
            if (rd_pending && rd_delay == 0) begin
                r_valid_i  = 1'b1;
                r_data_i   = mem_word(rd_addr);
                rd_pending = 1'b0;
            end else if (rd_pending) begin
                rd_delay--;
            end
            ar_ready_i = (rand_below(2) == 1);
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            #2;
            if (!bp_mode) wb_ready_i = 1'b1;
            else if (rand_below(4) == 0) wb_ready_i = !wb_ready_i;
        end
    end

    // retire the head once its writeback went through
    initial begin
        forever begin
            @(posedge clk);
            #2;
            if (!rst && dis_count != com_count && done[tb_head]) begin
                commit_en_i   = 1'b1;
                done[tb_head] = 1'b0;
                tb_head       = (tb_head + 1) % LQ_DEPTH;
                com_count++;
            end else begin
                commit_en_i = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        seed = 33289;
        rst = 1'b1;
        dis_en_i = 1'b0;
        iss_en_i = 1'b0;
        iss_idx_i = '0;
        iss_addr_i = '0;
        iss_size_i = '0;
        iss_uext_i = 1'b0;
        iss_rd_i = '0;
        iss_miss_i = 1'b0;
        iss_uncache_i = 1'b0;
        iss_data_i = '0;
        refill_en_i = 1'b0;
        refill_idx_i = '0;
        refill_data_i = '0;
        commit_en_i = 1'b0;
        wb_ready_i = 1'b1;
        ar_ready_i = 1'b0;
        r_valid_i = 1'b0;
        r_data_i = '0;
        err_count = 0;
        tests_ok = 0;
        tests_bad = 0;
        cycles = 0;
        tb_head = 0;
        tb_tail = 0;
        dis_count = 0;
        com_count = 0;
        bp_mode = 1'b0;
        rd_pending = 1'b0;
        rd_delay = 0;
        rd_addr = '0;
        for (int i = 0; i < LQ_DEPTH; i++) begin
            pending[i] = 1'b0;
            done[i] = 1'b0;
            unc[i] = 1'b0;
        end
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        @(posedge clk);
        #2;
        run_test("hits", 6, 0, 1'b0);
        run_test("misses", 6, 1, 1'b0);
        run_test("backpressure", 6, 2, 1'b1);
        run_test("uncached", 6, 3, 1'b0);
        full_wrap_test();
        run_test("mixed", 6, 3, 1'b1);
        // bound assertion failures count as errors too
        err_count += u_lq_top.u_lq_sva.fail_count;
        $display("tests passed %0d, failed %0d, errors %0d", tests_ok, tests_bad, err_count);
        if (err_count == 0 && tests_bad == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
